//--- Makefile
TOOL = verilator
FLAGS = --binary --timing -j 0
TOP = tb_function_generator
FILE_LIST = tb.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Testbench passed

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_function_generator.sv
`timescale 1ns/1ns

`include "fg_consts.svh"

module tb_function_generator;

	localparam int clock_period = 20;
	localparam int reset_cycles = 16;
	localparam int table_depth = 2 ** `FG_ADDRESS_WIDTH;

	// edges from the one that samples run high to the first bit
	// MSB of word 0 shows in the third cycle
	localparam int start_latency = 2;

	// quiet cycles before run goes high again
	localparam int write_settle_cycles = 4;

	// cycles checked after run drops
	localparam int stop_check_cycles = 6;

	// playback lengths
	localparam int long_play_bound = 3 * table_depth * `FG_SAMPLE_WIDTH + start_latency;
	localparam int short_play_cycles = 30 * `FG_SAMPLE_WIDTH + start_latency;
	localparam int run_overhead = stop_check_cycles + 2;

	// host traffic of the two load phases
	localparam int full_load_cycles = `FG_CHANNELS * (table_depth + 1) + write_settle_cycles + 1;
	localparam int length_load_cycles = `FG_CHANNELS + 1 + write_settle_cycles + 1;

	localparam int total_cycles = reset_cycles + 4 + full_load_cycles + length_load_cycles +
		long_play_bound + 2 * short_play_cycles + 3 * run_overhead;
	localparam int watchdog_cycles = 2 * total_cycles + 200;

	// galois feedback polynomial x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic clock;
	logic reset;
	fg_pkg::host_write_t host_write;
	logic write_enable;
	logic length_enable;
	logic run;
	fg_pkg::channel_id_t monitor_select;
	logic [`FG_CHANNELS-1:0] bit_out;
	fg_pkg::sample_t monitor_word;

	// reference model
	fg_pkg::sample_t model_table [`FG_CHANNELS][table_depth];
	fg_pkg::sample_address_t model_last [`FG_CHANNELS];
	fg_pkg::sample_t expected_monitor;
	fg_pkg::channel_id_t current_select;

	logic [31:0] lfsr_state;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ lfsr_taps;
		end
		return state >> 1;
	endfunction

	// one lfsr step per returned bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// table wraps after its last address
	function automatic fg_pkg::sample_t expected_word(input int ch, input int word_index);
		int table_length;
		table_length = int'(model_last[ch]) + 1;
		return model_table[ch][word_index % table_length];
	endfunction

	// k counts edges from the one that samples run high
	function automatic logic [`FG_CHANNELS-1:0] expected_bits(input int k);
		logic [`FG_CHANNELS-1:0] bits;
		fg_pkg::sample_t word;
		int word_index;
		int bit_index;
		int ch;
		bits = '0;
		if (k >= start_latency) begin
			word_index = (k - start_latency) / `FG_SAMPLE_WIDTH;
			// msb first
			bit_index = `FG_SAMPLE_WIDTH - 1 - (k - start_latency) % `FG_SAMPLE_WIDTH;
			for (ch = 0; ch < `FG_CHANNELS; ch++) begin
				word = expected_word(ch, word_index);
				bits[ch] = word[bit_index];
			end
		end
		return bits;
	endfunction

	task automatic compare_bit(input logic [`FG_CHANNELS-1:0] actual,
		input logic [`FG_CHANNELS-1:0] expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, expected %b got %b", $time, what, expected, actual);
			$display("Testbench failed");
			$fatal(1, "bit_out mismatch");
		end
	endtask

	task automatic compare_word(input fg_pkg::sample_t actual, input fg_pkg::sample_t expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, expected %h got %h", $time, what, expected, actual);
			$display("Testbench failed");
			$fatal(1, "monitor_word mismatch");
		end
	endtask

	// one host cycle with the model following the strobe rules
	task automatic host_access(input fg_pkg::channel_id_t ch,
		input fg_pkg::sample_address_t address, input fg_pkg::sample_t data,
		input logic write_strobe, input logic length_strobe);
		@(posedge clock);
		host_write <= '{channel: ch, address: address, data: data};
		write_enable <= write_strobe;
		length_enable <= length_strobe;
		// write wins when both strobes are high
		if (write_strobe) begin
			model_table[ch][address] = data;
		end else if (length_strobe) begin
			model_last[ch] = address;
		end
	endtask

	task automatic host_release;
		@(posedge clock);
		write_enable <= 1'b0;
		length_enable <= 1'b0;
		repeat (write_settle_cycles) @(posedge clock);
	endtask

	// run high for a while and then low with a check in every cycle
	task automatic play_and_check(input int play_cycles);
		fg_pkg::channel_id_t sampled_select;
		int k;
		@(posedge clock);
		run <= 1'b1;
		for (k = 0; k <= play_cycles; k++) begin
			@(posedge clock);
			// select value the DUT sees on this edge
			sampled_select = current_select;
			if (k >= start_latency && (k - start_latency) % `FG_SAMPLE_WIDTH == 0) begin
				expected_monitor = expected_word(sampled_select,
					(k - start_latency) / `FG_SAMPLE_WIDTH);
			end
			if (k == play_cycles) begin
				run <= 1'b0;
			end else if (random_bits(1) == 32'd1) begin
				current_select = fg_pkg::channel_id_t'(random_bits(2));
				monitor_select <= current_select;
			end
			@(negedge clock);
			compare_bit(bit_out, expected_bits(k), "bit_out during playback");
			compare_word(monitor_word, expected_monitor, "monitor_word during playback");
		end
		// quiet from the edge that samples run low
		repeat (stop_check_cycles) begin
			@(posedge clock);
			@(negedge clock);
			compare_bit(bit_out, '0, "bit_out after stop");
			compare_word(monitor_word, expected_monitor, "monitor_word after stop");
		end
	endtask

	function_generator dut_i (
		.clock(clock),
		.reset(reset),
		.host_write(host_write),
		.write_enable(write_enable),
		.length_enable(length_enable),
		.run(run),
		.monitor_select(monitor_select),
		.bit_out(bit_out),
		.monitor_word(monitor_word)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("timed out: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int longest;
		int ch;
		int address;
		reset = 1'b1;
		host_write = '0;
		write_enable = 1'b0;
		length_enable = 1'b0;
		run = 1'b0;
		monitor_select = '0;
		current_select = '0;
		expected_monitor = '0;
		lfsr_state = 32'h480cbf16;
		for (ch = 0; ch < `FG_CHANNELS; ch++) begin
			model_last[ch] = '0;
		end

		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;

		// outputs quiet after reset with run low
		repeat (4) begin
			@(negedge clock);
			compare_bit(bit_out, '0, "bit_out after reset");
			compare_word(monitor_word, '0, "monitor_word after reset");
		end

		// random tables and random lengths on every channel
		for (ch = 0; ch < `FG_CHANNELS; ch++) begin
			for (address = 0; address < table_depth; address++) begin
				host_access(fg_pkg::channel_id_t'(ch), fg_pkg::sample_address_t'(address),
					fg_pkg::sample_t'(random_bits(`FG_SAMPLE_WIDTH)), 1'b1, 1'b0);
			end
		end
		for (ch = 0; ch < `FG_CHANNELS; ch++) begin
			host_access(fg_pkg::channel_id_t'(ch),
				fg_pkg::sample_address_t'(random_bits(`FG_ADDRESS_WIDTH)),
				fg_pkg::sample_t'(random_bits(`FG_SAMPLE_WIDTH)), 1'b0, 1'b1);
		end
		host_release();

		// several wraps of the longest table
		longest = 0;
		for (ch = 0; ch < `FG_CHANNELS; ch++) begin
			if (int'(model_last[ch]) > longest) begin
				longest = int'(model_last[ch]);
			end
		end
		play_and_check(3 * (longest + 1) * `FG_SAMPLE_WIDTH + start_latency);

		// restart from address 0
		play_and_check(short_play_cycles);

		// short distinct lengths where channel 0 repeats word 0
		host_access(fg_pkg::channel_id_t'(0), fg_pkg::sample_address_t'(0), '0, 1'b0, 1'b1);
		host_access(fg_pkg::channel_id_t'(1), fg_pkg::sample_address_t'(1), '0, 1'b0, 1'b1);
		host_access(fg_pkg::channel_id_t'(2), fg_pkg::sample_address_t'(2), '0, 1'b0, 1'b1);
		host_access(fg_pkg::channel_id_t'(3), fg_pkg::sample_address_t'(5), '0, 1'b0, 1'b1);
		// both strobes so the data lands and the length stays at 5
		host_access(fg_pkg::channel_id_t'(3), fg_pkg::sample_address_t'(2),
			fg_pkg::sample_t'(random_bits(`FG_SAMPLE_WIDTH)), 1'b1, 1'b1);
		host_release();
		play_and_check(short_play_cycles);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- include/fg_consts.svh
`ifndef FG_CONSTS_SVH
`define FG_CONSTS_SVH

// sizing of the function generator

// number of playback channels
// each one has its own table and serial line
`define FG_CHANNELS 4

// bits per sample word
// also the serializer word length, one bit out per clock
`define FG_SAMPLE_WIDTH 8

// table depth is 2**FG_ADDRESS_WIDTH words per channel
`define FG_ADDRESS_WIDTH 6

// counts the bits of one word
// 2**FG_BIT_COUNT_WIDTH must equal FG_SAMPLE_WIDTH
`define FG_BIT_COUNT_WIDTH 3

// bit counter value that raises word_strobe
`define FG_STROBE_COUNT 0

// last bit counter value in a word
`define FG_LAST_BIT_COUNT (`FG_SAMPLE_WIDTH - 1)

`endif

//--- rtl/fg_pkg.sv
`include "fg_consts.svh"

package fg_pkg;

	// one waveform sample
	typedef logic [`FG_SAMPLE_WIDTH-1:0] sample_t;

	// address into one channel's table
	typedef logic [`FG_ADDRESS_WIDTH-1:0] sample_address_t;

	// channel number, 2 bits for 4 channels
	typedef logic [$clog2(`FG_CHANNELS)-1:0] channel_id_t;

	// write command for one channel memory, 15 bits
	typedef struct packed {
		logic enable;
		sample_address_t address;
		sample_t data;
	} wave_write_t;

	// request from the host, 16 bits
	// data is ignored for a length update
	typedef struct packed {
		channel_id_t channel;
		sample_address_t address;
		sample_t data;
	} host_write_t;

	// current word of every channel, slot n is channel n
	typedef sample_t [`FG_CHANNELS-1:0] channel_words_t;

	// serializer FSM
	typedef enum logic {
		idle,
		shifting
	} serializer_state_t;

endpackage

//--- rtl/function_generator.sv
`timescale 1ns/1ns

`include "fg_consts.svh"

module function_generator (
	input logic clock,
	input logic reset,
	input fg_pkg::host_write_t host_write,
	input logic write_enable,
	input logic length_enable,
	input logic run,
	input fg_pkg::channel_id_t monitor_select,
	output logic [`FG_CHANNELS-1:0] bit_out,
	output fg_pkg::sample_t monitor_word
);

	// loader to channels
	fg_pkg::wave_write_t channel_writes [`FG_CHANNELS];
	fg_pkg::sample_address_t last_addresses [`FG_CHANNELS];

	// serializer timing to channels, and words back
	logic word_strobe;
	fg_pkg::channel_words_t channel_words;

	waveform_loader loader_i (
		.clock(clock),
		.reset(reset),
		.host_write(host_write),
		.write_enable(write_enable),
		.length_enable(length_enable),
		.channel_writes(channel_writes),
		.last_addresses(last_addresses)
	);

	// one table and counter per output line
	for (genvar ch = 0; ch < `FG_CHANNELS; ch++) begin : g_channel
		waveform_channel channel_i (
			.clock(clock),
			.reset(reset),
			.channel_write(channel_writes[ch]),
			.last_address(last_addresses[ch]),
			.run(run),
			.word_strobe(word_strobe),
			.word(channel_words[ch])
		);
	end

	word_serializer serializer_i (
		.clock(clock),
		.reset(reset),
		.run(run),
		.channel_words(channel_words),
		.monitor_select(monitor_select),
		.word_strobe(word_strobe),
		.bit_out(bit_out),
		.monitor_word(monitor_word)
	);

endmodule

//--- rtl/waveform_channel.sv
`timescale 1ns/1ns

`include "fg_consts.svh"

module waveform_channel (
	input logic clock,
	input logic reset,
	input fg_pkg::wave_write_t channel_write,
	input fg_pkg::sample_address_t last_address,
	input logic run,
	input logic word_strobe,
	output fg_pkg::sample_t word
);

	localparam int DEPTH = 2 ** `FG_ADDRESS_WIDTH;

	// sample table
	fg_pkg::sample_t memory [DEPTH];

	// playback position
	fg_pkg::sample_address_t play_address;

	// at the end of the table
	logic at_last;

	assign at_last = (play_address == last_address);

	// host side write port
	always_ff @(posedge clock) begin
		if (channel_write.enable) begin
			memory[channel_write.address] <= channel_write.data;
		end
	end

	// registered read
	// word holds until the next strobe
	always_ff @(posedge clock) begin
		if (word_strobe) begin
			word <= memory[play_address];
		end
	end

	// address counter
	always_ff @(posedge clock) begin
		if (reset) begin
			play_address <= '0;
		end else if (!run) begin
			// stopped, next run starts from the top of the table
			play_address <= '0;
		end else if (word_strobe) begin
			if (at_last) begin
				// wrap after the last word
				play_address <= '0;
			end else begin
				play_address <= play_address + 1'b1;
			end
		end
	end

endmodule

//--- rtl/waveform_loader.sv
`timescale 1ns/1ns

`include "fg_consts.svh"

module waveform_loader (
	input logic clock,
	input logic reset,
	input fg_pkg::host_write_t host_write,
	input logic write_enable,
	input logic length_enable,
	output fg_pkg::wave_write_t channel_writes [`FG_CHANNELS],
	output fg_pkg::sample_address_t last_addresses [`FG_CHANNELS]
);

	// one hot decode of the channel field
	logic [`FG_CHANNELS-1:0] channel_hit;

	always_comb begin
		for (int i = 0; i < `FG_CHANNELS; i++) begin
			channel_hit[i] = (host_write.channel == fg_pkg::channel_id_t'(i));
		end
	end

	// registered write commands
	// memory sees the write one cycle after the strobe
	always_ff @(posedge clock) begin
		for (int i = 0; i < `FG_CHANNELS; i++) begin
			// address and data fan out to all channels
			channel_writes[i].address <= host_write.address;
			channel_writes[i].data <= host_write.data;
			if (reset) begin
				channel_writes[i].enable <= 1'b0;
			end else begin
				// only the addressed channel is enabled
				channel_writes[i].enable <= write_enable && channel_hit[i];
			end
		end
	end

	// last playback address per channel
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `FG_CHANNELS; i++) begin
				last_addresses[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `FG_CHANNELS; i++) begin
				// a sample write wins over a length update in the same cycle
				if (length_enable && !write_enable && channel_hit[i]) begin
					last_addresses[i] <= host_write.address;
				end
			end
		end
	end

endmodule

//--- rtl/word_serializer.sv
`timescale 1ns/1ns

`include "fg_consts.svh"

module word_serializer (
	input logic clock,
	input logic reset,
	input logic run,
	input fg_pkg::channel_words_t channel_words,
	input fg_pkg::channel_id_t monitor_select,
	output logic word_strobe,
	output logic [`FG_CHANNELS-1:0] bit_out,
	output fg_pkg::sample_t monitor_word
);

	fg_pkg::serializer_state_t state;

	// position inside the current word
	logic [`FG_BIT_COUNT_WIDTH-1:0] bit_count;

	// strobe delayed by one, channels have their word by then
	logic load_pending;

	// one shift register per channel
	fg_pkg::channel_words_t shift_registers;

	// one cycle pulse per word while shifting
	assign word_strobe = (state == fg_pkg::shifting) &&
		(bit_count == `FG_BIT_COUNT_WIDTH'(`FG_STROBE_COUNT));

	// msb first
	always_comb begin
		for (int i = 0; i < `FG_CHANNELS; i++) begin
			bit_out[i] = shift_registers[i][`FG_SAMPLE_WIDTH-1];
		end
	end

	// FSM and bit counter
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fg_pkg::idle;
			bit_count <= '0;
			load_pending <= 1'b0;
		end else if (!run) begin
			state <= fg_pkg::idle;
			bit_count <= '0;
			load_pending <= 1'b0;
		end else begin
			state <= fg_pkg::shifting;
			load_pending <= word_strobe;
			// counter starts at 0 on the first shifting cycle
			if (state == fg_pkg::shifting) begin
				if (bit_count == `FG_BIT_COUNT_WIDTH'(`FG_LAST_BIT_COUNT)) begin
					bit_count <= '0;
				end else begin
					bit_count <= bit_count + 1'b1;
				end
			end
		end
	end

	// load or shift, every channel in step
	always_ff @(posedge clock) begin
		if (reset || !run) begin
			// line goes quiet on the edge that sees run low
			shift_registers <= '0;
		end else if (load_pending) begin
			shift_registers <= channel_words;
		end else begin
			for (int i = 0; i < `FG_CHANNELS; i++) begin
				shift_registers[i] <= {shift_registers[i][`FG_SAMPLE_WIDTH-2:0], 1'b0};
			end
		end
	end

	// monitor follows the selected channel, once per word
	always_ff @(posedge clock) begin
		if (reset) begin
			monitor_word <= '0;
		end else if (run && load_pending) begin
			monitor_word <= channel_words[monitor_select];
		end
	end

endmodule

//--- tb.f
+incdir+include
rtl/fg_pkg.sv
rtl/waveform_loader.sv
rtl/waveform_channel.sv
rtl/word_serializer.sv
rtl/function_generator.sv
dv/tb_function_generator.sv
